//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/rv_core_pkg.sv
  - verilog/rv_regfile.sv
  - verilog/rv_alu.sv
  - verilog/rv_lsu_align.sv
  - verilog/rv_decoder.sv
  - verilog/rv_control.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - testbench/rv_core_asserts.sv
      - testbench/rv_core_tb.sv

//--- sources.f
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu_align.sv
verilog/rv_decoder.sv
verilog/rv_control.sv
verilog/rv_core.sv
testbench/rv_core_asserts.sv
testbench/rv_core_tb.sv

//--- testbench/rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts #(
  parameter logic [31:0] reset_vector = 32'h0000_0000
) (
  input logic        clk,
  input logic        reset,
  input logic        mem_valid,
  input logic        mem_instr,
  input logic        mem_ready,
  input logic [31:0] mem_addr,
  input logic [31:0] mem_wdata,
  input logic [3:0]  mem_wstrb,
  input logic        trap
);

  // read by the testbench top to end the run
  int error_count = 0;

  quiet_in_reset: assert property (@(posedge clk) reset |=> !mem_valid && !trap)
    else begin
      $error("mem_valid or trap high after a reset cycle");
      error_count++;
    end

  // first request is an instruction read at the reset vector
  first_fetch: assert property (@(posedge clk)
    $fell(reset) |=> mem_valid && mem_instr && mem_addr == reset_vector && mem_wstrb == 4'b0000)
    else begin
      $error("first request after reset is not a fetch at the reset vector");
      error_count++;
    end

  hold_request: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=>
      mem_valid && $stable(mem_addr) && $stable(mem_instr) && $stable(mem_wstrb))
    else begin
      $error("request changed or dropped while waiting for ready");
      error_count++;
    end

  hold_store_data: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready && mem_wstrb != 4'b0000 |=> $stable(mem_wdata))
    else begin
      $error("store data changed while waiting for ready");
      error_count++;
    end

  drop_after_ready: assert property (@(posedge clk) disable iff (reset)
    mem_valid && mem_ready |=> !mem_valid)
    else begin
      $error("mem_valid still high in the cycle after ready");
      error_count++;
    end

  // once trapped the core stays silent until reset
  trap_sticky: assert property (@(posedge clk) disable iff (reset) trap |=> trap && !mem_valid)
    else begin
      $error("trap dropped or a request was made after trap");
      error_count++;
    end

endmodule

bind rv_core rv_core_asserts #(
  .reset_vector(reset_vector)
) rv_core_asserts_inst (
  .clk(clk),
  .reset(reset),
  .mem_valid(mem_valid),
  .mem_instr(mem_instr),
  .mem_ready(mem_ready),
  .mem_addr(mem_addr),
  .mem_wdata(mem_wdata),
  .mem_wstrb(mem_wstrb),
  .trap(trap)
);

//--- testbench/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  localparam logic [31:0] boot_addr = 32'h0000_0000;
  localparam logic [31:0] data_base = 32'h0000_0200;
  localparam int mem_words = 256;
  localparam logic [31:0] rand_seed = 32'hf1e4_72bc;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic mem_ready = 1'b0;
  logic [31:0] mem_rdata = 32'h0;
  logic mem_valid;
  logic mem_instr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0] mem_wstrb;
  logic trap;

  logic [31:0] mem [mem_words];
  string exp_name [$];
  logic [31:0] exp_addr [$];
  logic [3:0] exp_strb [$];
  logic [31:0] exp_data [$];
  int prog_len = 0;
  int store_count = 0;
  bit program_loaded = 1'b0;

  rv_core #(
    .reset_vector(boot_addr)
  ) rv_core_inst (
    .clk(clk),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_instr(mem_instr),
    .mem_ready(mem_ready),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .trap(trap)
  );

  always #20 clk = ~clk;

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op};
  endfunction

  function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] s_format(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::store};
  endfunction

  function automatic logic [31:0] b_format(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::branch};
  endfunction

  function automatic logic [31:0] u_format(logic [19:0] imm, logic [4:0] rd, logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  function automatic logic [31:0] j_format(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::jal};
  endfunction

  task automatic put(input logic [31:0] instr);
    mem[prog_len] = instr;
    prog_len++;
  endtask

  task automatic expect_store(input string name, input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] data);
    exp_name.push_back(name);
    exp_addr.push_back(addr);
    exp_strb.push_back(strb);
    exp_data.push_back(data);
  endtask

  // sw rs2 to the data area at an offset from x1
  task automatic store_word(input logic [4:0] rs2, input logic [11:0] off, input string name,
                            input logic [31:0] value);
    put(s_format(off, rs2, 5'd1, rv_isa_pkg::mem_word));
    expect_store(name, data_base + {20'h0, off}, 4'b1111, value);
  endtask

  // a store that must never run
  task automatic put_sentinel();
    put(s_format(12'h07c, 5'd2, 5'd1, rv_isa_pkg::mem_word));
  endtask

  task automatic load_program();
    logic [31:0] mark;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = ~(i << 2);
    end
    // x1 holds the data base with x2 = -7 and x3 = 5
    put(i_format(12'h200, 5'd0, 3'b000, 5'd1, rv_isa_pkg::op_imm));
    put(i_format(12'hff9, 5'd0, 3'b000, 5'd2, rv_isa_pkg::op_imm));
    put(i_format(12'h005, 5'd0, 3'b000, 5'd3, rv_isa_pkg::op_imm));
    put(r_format(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
    store_word(5'd4, 12'h000, "add", 32'hffff_fffe);
    put(r_format(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
    store_word(5'd4, 12'h004, "sub", 32'h0000_000c);
    put(r_format(7'h00, 5'd3, 5'd2, 3'b010, 5'd4));
    store_word(5'd4, 12'h008, "slt", 32'h0000_0001);
    put(r_format(7'h00, 5'd3, 5'd2, 3'b011, 5'd4));
    store_word(5'd4, 12'h00c, "sltu", 32'h0000_0000);
    put(i_format({7'h20, 5'd1}, 5'd2, 3'b101, 5'd4, rv_isa_pkg::op_imm));
    store_word(5'd4, 12'h010, "srai", 32'hffff_fffc);
    put(r_format(7'h00, 5'd3, 5'd2, 3'b101, 5'd4));
    store_word(5'd4, 12'h014, "srl", 32'h07ff_ffff);
    put(r_format(7'h00, 5'd3, 5'd3, 3'b001, 5'd4));
    store_word(5'd4, 12'h018, "sll", 32'h0000_00a0);
    put(i_format(12'h0f0, 5'd2, 3'b100, 5'd4, rv_isa_pkg::op_imm));
    store_word(5'd4, 12'h01c, "xori", 32'hffff_ff09);
    put(i_format(12'h030, 5'd3, 3'b110, 5'd4, rv_isa_pkg::op_imm));
    put(r_format(7'h00, 5'd4, 5'd2, 3'b111, 5'd5));
    store_word(5'd5, 12'h020, "ori_and", 32'h0000_0031);
    put(i_format(12'hffa, 5'd2, 3'b010, 5'd4, rv_isa_pkg::op_imm));
    put(i_format(12'hfff, 5'd3, 3'b011, 5'd5, rv_isa_pkg::op_imm));
    put(i_format({7'h00, 5'd4}, 5'd5, 3'b001, 5'd5, rv_isa_pkg::op_imm));
    put(r_format(7'h00, 5'd5, 5'd4, 3'b000, 5'd4));
    store_word(5'd4, 12'h024, "slti_sltiu_slli", 32'h0000_0011);
    put(u_format(20'h12345, 5'd6, rv_isa_pkg::lui));
    put(i_format(12'h678, 5'd6, 3'b000, 5'd6, rv_isa_pkg::op_imm));
    store_word(5'd6, 12'h028, "lui_addi", 32'h1234_5678);
    mark = prog_len * 4;
    put(u_format(20'h00001, 5'd7, rv_isa_pkg::auipc));
    store_word(5'd7, 12'h02c, "auipc", mark + 32'h1000);

    // narrow stores into the word at 0x230 and the low half at 0x248
    put(s_format(12'h030, 5'd6, 5'd1, rv_isa_pkg::mem_byte));
    expect_store("sb_lane0", 32'h230, 4'b0001, 32'h7878_7878);
    put(s_format(12'h031, 5'd2, 5'd1, rv_isa_pkg::mem_byte));
    expect_store("sb_lane1", 32'h230, 4'b0010, 32'hf9f9_f9f9);
    put(s_format(12'h032, 5'd2, 5'd1, rv_isa_pkg::mem_half));
    expect_store("sh_upper", 32'h230, 4'b1100, 32'hfff9_fff9);
    put(s_format(12'h048, 5'd6, 5'd1, rv_isa_pkg::mem_half));
    expect_store("sh_lower", 32'h248, 4'b0011, 32'h5678_5678);
    put(i_format(12'h030, 5'd1, rv_isa_pkg::mem_byte, 5'd8, rv_isa_pkg::load));
    store_word(5'd8, 12'h034, "lb_positive", 32'h0000_0078);
    put(i_format(12'h031, 5'd1, rv_isa_pkg::mem_byte, 5'd8, rv_isa_pkg::load));
    store_word(5'd8, 12'h038, "lb_negative", 32'hffff_fff9);
    put(i_format(12'h031, 5'd1, rv_isa_pkg::mem_byte_u, 5'd8, rv_isa_pkg::load));
    store_word(5'd8, 12'h03c, "lbu", 32'h0000_00f9);
    put(i_format(12'h032, 5'd1, rv_isa_pkg::mem_half, 5'd8, rv_isa_pkg::load));
    store_word(5'd8, 12'h040, "lh_negative", 32'hffff_fff9);
    put(i_format(12'h032, 5'd1, rv_isa_pkg::mem_half_u, 5'd8, rv_isa_pkg::load));
    store_word(5'd8, 12'h044, "lhu", 32'h0000_fff9);
    put(i_format(12'h048, 5'd1, rv_isa_pkg::mem_half, 5'd8, rv_isa_pkg::load));
    store_word(5'd8, 12'h04c, "lh_positive", 32'h0000_5678);

    // taken branches skip a sentinel while not-taken ones reach a store
    put(b_format(13'd8, 5'd3, 5'd3, rv_isa_pkg::beq));
    put_sentinel();
    put(b_format(13'd8, 5'd3, 5'd3, rv_isa_pkg::bne));
    store_word(5'd3, 12'h050, "bne_not_taken", 32'h0000_0005);
    put(b_format(13'd8, 5'd3, 5'd2, rv_isa_pkg::blt));
    put_sentinel();
    put(b_format(13'd8, 5'd3, 5'd2, rv_isa_pkg::bltu));
    store_word(5'd3, 12'h054, "bltu_not_taken", 32'h0000_0005);
    put(b_format(13'd8, 5'd2, 5'd3, rv_isa_pkg::bge));
    put_sentinel();
    put(b_format(13'd8, 5'd2, 5'd3, rv_isa_pkg::bgeu));
    store_word(5'd3, 12'h058, "bgeu_not_taken", 32'h0000_0005);
    mark = prog_len * 4;
    put(j_format(21'd8, 5'd9));
    put_sentinel();
    store_word(5'd9, 12'h05c, "jal_link", mark + 32'd4);
    // jalr offset 17 has bit 0 set and the target clears it
    mark = prog_len * 4;
    put(u_format(20'h00000, 5'd10, rv_isa_pkg::auipc));
    put(i_format(12'd17, 5'd10, 3'b000, 5'd11, rv_isa_pkg::jalr));
    put_sentinel();
    put_sentinel();
    store_word(5'd11, 12'h060, "jalr_link", mark + 32'd8);
    // misaligned lw ends the program with a trap
    put(i_format(12'h002, 5'd1, rv_isa_pkg::mem_word, 5'd12, rv_isa_pkg::load));
    program_loaded = 1'b1;
  endtask

  task automatic check_store();
    int n;
    n = store_count;
    assert (n < exp_addr.size())
      else report_problem("the core made a store beyond the expected list");
    assert (mem_instr == 1'b0)
      else report_mismatch({exp_name[n], " mem_instr"}, 32'h0, {31'h0, mem_instr});
    assert (mem_addr == exp_addr[n])
      else report_mismatch({exp_name[n], " address"}, exp_addr[n], mem_addr);
    assert (mem_wstrb == exp_strb[n])
      else report_mismatch({exp_name[n], " strobe"}, {28'h0, exp_strb[n]}, {28'h0, mem_wstrb});
    assert (mem_wdata == exp_data[n])
      else report_mismatch({exp_name[n], " data"}, exp_data[n], mem_wdata);
    store_count++;
  endtask

  task automatic write_memory();
    for (int b = 0; b < 4; b++) begin
      if (mem_wstrb[b]) begin
        mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
      end
    end
  endtask

  // memory responder gives ready after 0 to 3 idle cycles
  initial begin
    int unsigned delay;
    void'($urandom(rand_seed));
    forever begin
      @(negedge clk);
      mem_ready = 1'b0;
      if (!reset && mem_valid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        assert (mem_addr < mem_words * 4) else report_problem("access outside the memory model");
        if (mem_wstrb != 4'b0000) begin
          check_store();
          write_memory();
        end
        mem_rdata = mem[mem_addr[9:2]];
        mem_ready = 1'b1;
      end
    end
  end

  always @(negedge clk) begin
    assert (rv_core_inst.rv_core_asserts_inst.error_count == 0)
      else report_problem("a bus protocol or trap assertion failed");
  end

  // up to 12 cycles per instruction and a wide margin for loops through the program
  initial begin
    wait (program_loaded);
    repeat (prog_len * 20 * 12) @(posedge clk);
    report_problem("watchdog expired, the core hung");
  end

  initial begin
    load_program();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    wait (trap === 1'b1);
    // a few cycles for the trap assertions to run
    repeat (4) @(negedge clk);
    if (store_count == exp_addr.size()) begin
      $display("Test OK");
      $finish;
    end else begin
      report_problem("trap raised before all expected stores were made");
    end
  end

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
  input  rv_core_pkg::instr_class_t   instr_class,
  input  rv_core_pkg::alu_op_t        alu_op,
  input  logic                        i_type,
  input  rv_isa_pkg::branch_funct_t   branch_funct,
  input  logic [rv_isa_pkg::xlen-1:0] pc,
  input  logic [rv_isa_pkg::xlen-1:0] imm,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  output logic [rv_isa_pkg::xlen-1:0] alu_result,
  output logic                        branch_taken,
  output logic [rv_isa_pkg::xlen-1:0] jump_target,
  output logic [rv_isa_pkg::xlen-1:0] ls_addr
);

  logic [rv_isa_pkg::xlen-1:0] operand_b;
  logic [4:0] shamt;
  logic [rv_isa_pkg::xlen-1:0] base_sum;
  logic [rv_isa_pkg::xlen-1:0] pc_sum;
  logic [rv_isa_pkg::xlen-1:0] op_result;
  logic eq;
  logic lt;
  logic ltu;

  assign operand_b = i_type ? imm : rs2_data;
  assign shamt = operand_b[4:0];
  assign base_sum = rs1_data + imm;
  assign pc_sum = pc + imm;
  assign ls_addr = base_sum;
  // jalr is the only jump with an I-type immediate
  assign jump_target = i_type ? {base_sum[rv_isa_pkg::xlen-1:1], 1'b0} : pc_sum;

  // branches see rs2 here since they are never I-type
  assign eq = rs1_data == operand_b;
  assign lt = $signed(rs1_data) < $signed(operand_b);
  assign ltu = rs1_data < operand_b;

  always_comb begin
    case (branch_funct)
      rv_isa_pkg::beq: branch_taken = eq;
      rv_isa_pkg::bne: branch_taken = !eq;
      rv_isa_pkg::blt: branch_taken = lt;
      rv_isa_pkg::bge: branch_taken = !lt;
      rv_isa_pkg::bltu: branch_taken = ltu;
      rv_isa_pkg::bgeu: branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op)
      rv_core_pkg::add: op_result = rs1_data + operand_b;
      rv_core_pkg::sub: op_result = rs1_data - operand_b;
      rv_core_pkg::sll: op_result = rs1_data << shamt;
      rv_core_pkg::slt: op_result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt};
      rv_core_pkg::sltu: op_result = {{(rv_isa_pkg::xlen-1){1'b0}}, ltu};
      rv_core_pkg::xor_op: op_result = rs1_data ^ operand_b;
      rv_core_pkg::srl: op_result = rs1_data >> shamt;
      rv_core_pkg::sra: op_result = $signed(rs1_data) >>> shamt;
      rv_core_pkg::or_op: op_result = rs1_data | operand_b;
      default: op_result = rs1_data & operand_b;
    endcase
  end

  always_comb begin
    case (instr_class)
      rv_core_pkg::cls_lui: alu_result = imm;
      rv_core_pkg::cls_auipc: alu_result = pc_sum;
      rv_core_pkg::cls_jump: alu_result = pc + rv_isa_pkg::instr_step;
      default: alu_result = op_result;
    endcase
  end

endmodule

//--- verilog/rv_control.sv
`timescale 1ns/10ps

module rv_control #(
  parameter logic [31:0] reset_vector = 32'h0000_0000
) (
  input  logic                                  clk,
  input  logic                                  reset,
  output logic                                  mem_valid,
  output logic                                  mem_instr,
  input  logic                                  mem_ready,
  output logic [rv_isa_pkg::xlen-1:0]           mem_addr,
  output logic [rv_isa_pkg::xlen-1:0]           mem_wdata,
  output logic [3:0]                            mem_wstrb,
  input  logic [rv_isa_pkg::xlen-1:0]           mem_rdata,
  output logic                                  trap,
  output logic [rv_isa_pkg::xlen-1:0]           instr,
  output logic [rv_isa_pkg::xlen-1:0]           pc,
  input  rv_core_pkg::instr_class_t             instr_class,
  input  logic [rv_isa_pkg::reg_addr_width-1:0] rd,
  input  logic [rv_isa_pkg::xlen-1:0]           alu_result,
  input  logic                                  branch_taken,
  input  logic [rv_isa_pkg::xlen-1:0]           jump_target,
  input  logic [rv_isa_pkg::xlen-1:0]           ls_addr,
  input  logic [3:0]                            store_wstrb,
  input  logic [rv_isa_pkg::xlen-1:0]           store_wdata,
  input  logic [rv_isa_pkg::xlen-1:0]           load_data,
  input  logic                                  misaligned,
  output logic                                  reg_we,
  output logic [rv_isa_pkg::reg_addr_width-1:0] reg_waddr,
  output logic [rv_isa_pkg::xlen-1:0]           reg_wdata
);

  rv_core_pkg::ctrl_state_t state;
  logic [rv_isa_pkg::xlen-1:0] next_pc;
  logic [rv_isa_pkg::xlen-1:0] result;

  assign reg_we = state == rv_core_pkg::reg_write;
  assign reg_waddr = rd;
  assign reg_wdata = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_core_pkg::fetch_instr;
      mem_valid <= 1'b0;
      trap <= 1'b0;
      next_pc <= reset_vector;
    end else begin
      case (state)
        rv_core_pkg::fetch_instr: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_addr <= next_pc;
          mem_wstrb <= 4'b0000;
          state <= rv_core_pkg::ready_instr;
        end
        rv_core_pkg::ready_instr: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            pc <= mem_addr;
            instr <= mem_rdata;
            state <= rv_core_pkg::decode_instr;
          end
        end
        // register reads and the immediate settle through the decoder
        rv_core_pkg::decode_instr: begin
          state <= rv_core_pkg::execute_instr;
        end
        rv_core_pkg::execute_instr: begin
          case (instr_class)
            rv_core_pkg::cls_lui, rv_core_pkg::cls_auipc, rv_core_pkg::cls_alu: begin
              result <= alu_result;
              next_pc <= pc + rv_isa_pkg::instr_step;
              state <= rv_core_pkg::reg_write;
            end
            rv_core_pkg::cls_jump: begin
              // link value comes from the alu
              result <= alu_result;
              next_pc <= jump_target;
              state <= rv_core_pkg::check_pc;
            end
            rv_core_pkg::cls_branch: begin
              next_pc <= branch_taken ? jump_target : pc + rv_isa_pkg::instr_step;
              state <= rv_core_pkg::check_pc;
            end
            rv_core_pkg::cls_load, rv_core_pkg::cls_store: begin
              if (misaligned) begin
                state <= rv_core_pkg::cpu_trap;
              end else begin
                // strobe is zero for a load
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr <= {ls_addr[rv_isa_pkg::xlen-1:2], 2'b00};
                mem_wstrb <= store_wstrb;
                mem_wdata <= store_wdata;
                next_pc <= pc + rv_isa_pkg::instr_step;
                if (instr_class == rv_core_pkg::cls_store) begin
                  state <= rv_core_pkg::finish_store;
                end else begin
                  state <= rv_core_pkg::finish_load;
                end
              end
            end
            default: begin
              state <= rv_core_pkg::cpu_trap;
            end
          endcase
        end
        rv_core_pkg::finish_load: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            result <= load_data;
            state <= rv_core_pkg::reg_write;
          end
        end
        rv_core_pkg::finish_store: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= rv_core_pkg::fetch_instr;
          end
        end
        // targets must be word aligned without the C extension
        rv_core_pkg::check_pc: begin
          if (|next_pc[1:0]) begin
            state <= rv_core_pkg::cpu_trap;
          end else if (instr_class == rv_core_pkg::cls_branch) begin
            state <= rv_core_pkg::fetch_instr;
          end else begin
            state <= rv_core_pkg::reg_write;
          end
        end
        rv_core_pkg::reg_write: begin
          state <= rv_core_pkg::fetch_instr;
        end
        default: begin
          trap <= 1'b1;
        end
      endcase
    end
  end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/10ps

module rv_core #(
  parameter logic [31:0] reset_vector = 32'h0000_0000
) (
  input  logic                        clk,
  input  logic                        reset,
  output logic                        mem_valid,
  output logic                        mem_instr,
  input  logic                        mem_ready,
  output logic [rv_isa_pkg::xlen-1:0] mem_addr,
  output logic [rv_isa_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]                  mem_wstrb,
  input  logic [rv_isa_pkg::xlen-1:0] mem_rdata,
  output logic                        trap
);

  logic [rv_isa_pkg::xlen-1:0] instr;
  logic [rv_isa_pkg::xlen-1:0] pc;
  rv_core_pkg::instr_class_t instr_class;
  rv_core_pkg::alu_op_t alu_op;
  logic i_type;
  rv_isa_pkg::mem_funct_t mem_funct;
  rv_isa_pkg::branch_funct_t branch_funct;
  logic [rv_isa_pkg::reg_addr_width-1:0] rd;
  logic [rv_isa_pkg::reg_addr_width-1:0] rs1;
  logic [rv_isa_pkg::reg_addr_width-1:0] rs2;
  logic [rv_isa_pkg::xlen-1:0] imm;
  logic [rv_isa_pkg::xlen-1:0] rs1_data;
  logic [rv_isa_pkg::xlen-1:0] rs2_data;
  logic reg_we;
  logic [rv_isa_pkg::reg_addr_width-1:0] reg_waddr;
  logic [rv_isa_pkg::xlen-1:0] reg_wdata;
  logic [rv_isa_pkg::xlen-1:0] alu_result;
  logic branch_taken;
  logic [rv_isa_pkg::xlen-1:0] jump_target;
  logic [rv_isa_pkg::xlen-1:0] ls_addr;
  logic [3:0] store_wstrb;
  logic [rv_isa_pkg::xlen-1:0] store_wdata;
  logic [rv_isa_pkg::xlen-1:0] load_data;
  logic misaligned;

  rv_control #(
    .reset_vector(reset_vector)
  ) rv_control_inst (
    .clk(clk),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_instr(mem_instr),
    .mem_ready(mem_ready),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .trap(trap),
    .instr(instr),
    .pc(pc),
    .instr_class(instr_class),
    .rd(rd),
    .alu_result(alu_result),
    .branch_taken(branch_taken),
    .jump_target(jump_target),
    .ls_addr(ls_addr),
    .store_wstrb(store_wstrb),
    .store_wdata(store_wdata),
    .load_data(load_data),
    .misaligned(misaligned),
    .reg_we(reg_we),
    .reg_waddr(reg_waddr),
    .reg_wdata(reg_wdata)
  );

  rv_decoder rv_decoder_inst (
    .instr(instr),
    .instr_class(instr_class),
    .alu_op(alu_op),
    .i_type(i_type),
    .mem_funct(mem_funct),
    .branch_funct(branch_funct),
    .rd(rd),
    .rs1(rs1),
    .rs2(rs2),
    .imm(imm)
  );

  rv_regfile rv_regfile_inst (
    .clk(clk),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we(reg_we),
    .waddr(reg_waddr),
    .wdata(reg_wdata)
  );

  rv_alu rv_alu_inst (
    .instr_class(instr_class),
    .alu_op(alu_op),
    .i_type(i_type),
    .branch_funct(branch_funct),
    .pc(pc),
    .imm(imm),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .alu_result(alu_result),
    .branch_taken(branch_taken),
    .jump_target(jump_target),
    .ls_addr(ls_addr)
  );

  rv_lsu_align rv_lsu_align_inst (
    .ls_addr(ls_addr),
    .mem_funct(mem_funct),
    .store(instr_class == rv_core_pkg::cls_store),
    .rs2_data(rs2_data),
    .mem_rdata(mem_rdata),
    .store_wstrb(store_wstrb),
    .store_wdata(store_wdata),
    .load_data(load_data),
    .misaligned(misaligned)
  );

endmodule

//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

  typedef enum logic [3:0] {
    fetch_instr,
    ready_instr,
    decode_instr,
    execute_instr,
    finish_load,
    finish_store,
    check_pc,
    reg_write,
    cpu_trap
  } ctrl_state_t;

  typedef enum logic [3:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op
  } alu_op_t;

  // selects what the execute step does with an instruction
  typedef enum logic [2:0] {
    cls_lui, cls_auipc, cls_jump, cls_branch, cls_load, cls_store, cls_alu, cls_invalid
  } instr_class_t;

endpackage

//--- verilog/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
  input  logic [rv_isa_pkg::xlen-1:0]           instr,
  output rv_core_pkg::instr_class_t             instr_class,
  output rv_core_pkg::alu_op_t                  alu_op,
  output logic                                  i_type,
  output rv_isa_pkg::mem_funct_t                mem_funct,
  output rv_isa_pkg::branch_funct_t             branch_funct,
  output logic [rv_isa_pkg::reg_addr_width-1:0] rd,
  output logic [rv_isa_pkg::reg_addr_width-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_width-1:0] rs2,
  output logic [rv_isa_pkg::xlen-1:0]           imm
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [rv_isa_pkg::xlen-1:0] i_imm;
  logic [rv_isa_pkg::xlen-1:0] s_imm;
  logic [rv_isa_pkg::xlen-1:0] b_imm;
  logic [rv_isa_pkg::xlen-1:0] u_imm;
  logic [rv_isa_pkg::xlen-1:0] j_imm;
  rv_core_pkg::alu_op_t funct3_op;

  assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign mem_funct = rv_isa_pkg::mem_funct_t'(funct3);
  assign branch_funct = rv_isa_pkg::branch_funct_t'(funct3);
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  // branches and stores carry immediate bits in the rd field
  assign rd = (opcode == rv_isa_pkg::branch || opcode == rv_isa_pkg::store) ? '0 : instr[11:7];

  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000: funct3_op = rv_core_pkg::add;
      3'b001: funct3_op = rv_core_pkg::sll;
      3'b010: funct3_op = rv_core_pkg::slt;
      3'b011: funct3_op = rv_core_pkg::sltu;
      3'b100: funct3_op = rv_core_pkg::xor_op;
      3'b101: funct3_op = rv_core_pkg::srl;
      3'b110: funct3_op = rv_core_pkg::or_op;
      default: funct3_op = rv_core_pkg::and_op;
    endcase
  end

  always_comb begin
    instr_class = rv_core_pkg::cls_invalid;
    alu_op = funct3_op;
    i_type = 1'b0;
    imm = i_imm;
    case (opcode)
      rv_isa_pkg::lui: begin
        instr_class = rv_core_pkg::cls_lui;
        imm = u_imm;
      end
      rv_isa_pkg::auipc: begin
        instr_class = rv_core_pkg::cls_auipc;
        imm = u_imm;
      end
      rv_isa_pkg::jal: begin
        instr_class = rv_core_pkg::cls_jump;
        imm = j_imm;
      end
      rv_isa_pkg::jalr: begin
        i_type = 1'b1;
        if (funct3 == 3'b000) begin
          instr_class = rv_core_pkg::cls_jump;
        end
      end
      rv_isa_pkg::branch: begin
        imm = b_imm;
        if (funct3[2:1] != 2'b01) begin
          instr_class = rv_core_pkg::cls_branch;
        end
      end
      rv_isa_pkg::load: begin
        i_type = 1'b1;
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          instr_class = rv_core_pkg::cls_load;
        end
      end
      rv_isa_pkg::store: begin
        imm = s_imm;
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          instr_class = rv_core_pkg::cls_store;
        end
      end
      rv_isa_pkg::op_imm: begin
        i_type = 1'b1;
        if (funct3 == 3'b001) begin
          if (funct7 == 7'b0000000) begin
            instr_class = rv_core_pkg::cls_alu;
          end
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b0000000) begin
            instr_class = rv_core_pkg::cls_alu;
          end else if (funct7 == 7'b0100000) begin
            instr_class = rv_core_pkg::cls_alu;
            alu_op = rv_core_pkg::sra;
          end
        end else begin
          instr_class = rv_core_pkg::cls_alu;
        end
      end
      rv_isa_pkg::op: begin
        if (funct7 == 7'b0000000) begin
          instr_class = rv_core_pkg::cls_alu;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          instr_class = rv_core_pkg::cls_alu;
          alu_op = rv_core_pkg::sub;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          instr_class = rv_core_pkg::cls_alu;
          alu_op = rv_core_pkg::sra;
        end
      end
      // ecall, ebreak and unknown opcodes stay invalid and trap
      default: begin
        instr_class = rv_core_pkg::cls_invalid;
      end
    endcase
  end

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int opcode_width = 7;
  localparam int funct3_width = 3;

  // no compressed instructions so the pc always moves by a full word
  localparam logic [xlen-1:0] instr_step = 32'd4;

  // major opcodes of RV32I
  typedef enum logic [opcode_width-1:0] {
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    branch = 7'b1100011,
    load   = 7'b0000011,
    store  = 7'b0100011,
    op_imm = 7'b0010011,
    op     = 7'b0110011,
    system = 7'b1110011
  } opcode_t;

  typedef enum logic [funct3_width-1:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct_t;

  // access size and extension for loads and stores
  typedef enum logic [funct3_width-1:0] {
    mem_byte   = 3'b000,
    mem_half   = 3'b001,
    mem_word   = 3'b010,
    mem_byte_u = 3'b100,
    mem_half_u = 3'b101
  } mem_funct_t;

endpackage

//--- verilog/rv_lsu_align.sv
`timescale 1ns/10ps

module rv_lsu_align (
  input  logic [rv_isa_pkg::xlen-1:0] ls_addr,
  input  rv_isa_pkg::mem_funct_t      mem_funct,
  input  logic                        store,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic [rv_isa_pkg::xlen-1:0] mem_rdata,
  output logic [3:0]                  store_wstrb,
  output logic [rv_isa_pkg::xlen-1:0] store_wdata,
  output logic [rv_isa_pkg::xlen-1:0] load_data,
  output logic                        misaligned
);

  logic [3:0] strobe;
  logic [7:0] load_byte;
  logic [15:0] load_half;

  always_comb begin
    case (mem_funct)
      rv_isa_pkg::mem_word: begin
        strobe = 4'b1111;
        store_wdata = rs2_data;
        misaligned = |ls_addr[1:0];
      end
      rv_isa_pkg::mem_half, rv_isa_pkg::mem_half_u: begin
        strobe = ls_addr[1] ? 4'b1100 : 4'b0011;
        store_wdata = {2{rs2_data[15:0]}};
        misaligned = ls_addr[0];
      end
      default: begin
        strobe = 4'b0001 << ls_addr[1:0];
        store_wdata = {4{rs2_data[7:0]}};
        misaligned = 1'b0;
      end
    endcase
  end

  // a zero strobe turns the request into a read
  assign store_wstrb = store ? strobe : 4'b0000;

  assign load_byte = mem_rdata[{ls_addr[1:0], 3'b000} +: 8];
  assign load_half = ls_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (mem_funct)
      rv_isa_pkg::mem_byte: load_data = {{24{load_byte[7]}}, load_byte};
      rv_isa_pkg::mem_byte_u: load_data = {24'b0, load_byte};
      rv_isa_pkg::mem_half: load_data = {{16{load_half[15]}}, load_half};
      rv_isa_pkg::mem_half_u: load_data = {16'b0, load_half};
      default: load_data = mem_rdata;
    endcase
  end

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                                  clk,
  input  logic [rv_isa_pkg::reg_addr_width-1:0] rs1,
  input  logic [rv_isa_pkg::reg_addr_width-1:0] rs2,
  output logic [rv_isa_pkg::xlen-1:0]           rs1_data,
  output logic [rv_isa_pkg::xlen-1:0]           rs2_data,
  input  logic                                  we,
  input  logic [rv_isa_pkg::reg_addr_width-1:0] waddr,
  input  logic [rv_isa_pkg::xlen-1:0]           wdata
);

  logic [rv_isa_pkg::xlen-1:0] regs [2**rv_isa_pkg::reg_addr_width];

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is never written so its read is forced
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule
